/* flist.f */
hdl/csr_pkg.sv
hdl/csr_bus_port.sv
hdl/csr_trap_regs.sv
hdl/csr_timer.sv
hdl/csr_unit.sv
testbench/csr_asserts.sv
testbench/csr_tb.sv

/* hdl/csr_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_bus_port import csr_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  csr_num_e          adr,
    input  logic [DATA_W-1:0] dat_w,
    input  logic [DATA_W-1:0] sel,
    output logic              ack,
    output logic [DATA_W-1:0] dat_r,
    output logic              wr_en,
    output csr_req_t          req,
    input  logic [DATA_W-1:0] trap_rdata,
    input  logic [DATA_W-1:0] timer_rdata
);

    logic new_req;

    // First cycle of a request, the raised ack closes it
    assign new_req = cyc && stb && !ack;
    assign wr_en = new_req && we;

    // sel carries a full bit mask here, not byte lanes
    always_comb begin
        req.num   = adr;
        req.we    = we;
        req.wdata = dat_w;
        req.wmask = sel;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= new_req;
        end
    end

    // Value before the write edge
    always_ff @(posedge clk) begin
        if (new_req) begin
            dat_r <= trap_rdata | timer_rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int DATA_W = 32;

    // Local interrupt enables, bit 10 not implemented
    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;
    localparam int TIMER_IS_BIT = 11;
    localparam int EENTRY_ALIGN = 6;

    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    typedef struct packed {
        csr_num_e          num;
        logic              we;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] wmask;
    } csr_req_t;

    typedef struct packed {
        logic              ex;
        logic              ertn;
        ecode_e            ecode;
        logic [8:0]        esubcode;
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] vaddr;
    } trap_event_t;

endpackage

`default_nettype wire

/* hdl/csr_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_timer import csr_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  csr_req_t          req,
    output logic [DATA_W-1:0] rdata,
    output logic              timer_pending
);

    logic [DATA_W-1:0] tid;
    logic              tcfg_en;
    logic              tcfg_periodic;
    logic [29:0]       tcfg_initval;
    logic [DATA_W-1:0] cnt;
    logic [DATA_W-1:0] wval;
    logic              tcfg_wr;

    always_comb begin
        case (req.num)
            CSR_TID:  rdata = tid;
            CSR_TCFG: rdata = {tcfg_initval, tcfg_periodic, tcfg_en};
            CSR_TVAL: rdata = cnt;
            default:  rdata = '0;
        endcase
    end

    assign wval = (req.wdata & req.wmask) | (rdata & ~req.wmask);
    assign tcfg_wr = wr_en && req.num == CSR_TCFG;

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
            tcfg_en <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval <= '0;
        end else if (wr_en && req.num == CSR_TID) begin
            tid <= wval;
        end else if (tcfg_wr) begin
            tcfg_en <= wval[0];
            tcfg_periodic <= wval[1];
            tcfg_initval <= wval[31:2];
        end
    end

    // All ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '1;
        end else if (tcfg_wr && wval[0]) begin
            cnt <= {wval[31:2], 2'b00};
        end else if (tcfg_en && cnt != '1) begin
            if (cnt == '0 && tcfg_periodic) begin
                cnt <= {tcfg_initval, 2'b00};
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (cnt == '0) begin
            timer_pending <= 1'b1;
        end else if (wr_en && req.num == CSR_TICLR && wval[0]) begin
            timer_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_trap_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs import csr_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  csr_req_t          req,
    input  trap_event_t       trap,
    input  logic              timer_pending,
    output logic [DATA_W-1:0] rdata,
    output logic              has_int,
    output logic [DATA_W-1:0] ex_entry,
    output logic [DATA_W-1:0] era_pc
);

    logic [1:0]                   crmd_plv;
    logic                         crmd_ie;
    logic [1:0]                   prmd_pplv;
    logic                         prmd_pie;
    logic [12:0]                  ecfg_lie;
    logic [1:0]                   estat_swi;
    ecode_e                       estat_ecode;
    logic [8:0]                   estat_esubcode;
    logic [12:0]                  estat_is;
    logic [DATA_W-1:0]            era;
    logic [DATA_W-1:0]            badv;
    logic [DATA_W-1:EENTRY_ALIGN] eentry_va;
    logic [DATA_W-1:0]            save [4];
    logic [DATA_W-1:0]            wval;
    logic                         addr_err;

    always_comb begin
        estat_is = '0;
        estat_is[1:0] = estat_swi;
        estat_is[TIMER_IS_BIT] = timer_pending;
    end

    always_comb begin
        case (req.num)
            CSR_CRMD:   rdata = {29'b0, crmd_ie, crmd_plv};
            CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
            CSR_ECFG:   rdata = {19'b0, ecfg_lie};
            CSR_ESTAT:  rdata = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = {eentry_va, {EENTRY_ALIGN{1'b0}}};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: rdata = save[req.num[1:0]];
            default:    rdata = '0;
        endcase
    end

    // New bits under the mask, current contents elsewhere
    assign wval = (req.wdata & req.wmask) | (rdata & ~req.wmask);

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie <= 1'b0;
        end else if (trap.ex) begin
            crmd_plv <= '0;
            crmd_ie <= 1'b0;
        end else if (trap.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie <= prmd_pie;
        end else if (wr_en && req.num == CSR_CRMD) begin
            crmd_plv <= wval[1:0];
            crmd_ie <= wval[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie <= 1'b0;
            estat_ecode <= ECODE_INT;
            estat_esubcode <= '0;
            era <= '0;
            badv <= '0;
        end else if (trap.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie <= crmd_ie;
            estat_ecode <= trap.ecode;
            estat_esubcode <= trap.esubcode;
            era <= trap.pc;
            if (addr_err) begin
                // Fetch errors fault on the pc itself
                badv <= (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) ?
                        trap.pc : trap.vaddr;
            end
        end else if (wr_en) begin
            if (req.num == CSR_PRMD) begin
                prmd_pplv <= wval[1:0];
                prmd_pie <= wval[2];
            end
            if (req.num == CSR_ERA) begin
                era <= wval;
            end
            if (req.num == CSR_BADV) begin
                badv <= wval;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            estat_swi <= '0;
            eentry_va <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else if (wr_en) begin
            case (req.num)
                CSR_ECFG:   ecfg_lie <= wval[12:0] & ECFG_LIE_MASK;
                CSR_ESTAT:  estat_swi <= wval[1:0];
                CSR_EENTRY: eentry_va <= wval[DATA_W-1:EENTRY_ALIGN];
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: save[req.num[1:0]] <= wval;
                default: ;
            endcase
        end
    end

    assign has_int = ((estat_is & ecfg_lie) != 13'b0) && crmd_ie;
    assign ex_entry = {eentry_va, {EENTRY_ALIGN{1'b0}}};
    assign era_pc = era;

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit import csr_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  csr_num_e          adr,
    input  logic [DATA_W-1:0] dat_w,
    input  logic [DATA_W-1:0] sel,
    output logic              ack,
    output logic [DATA_W-1:0] dat_r,
    input  trap_event_t       trap,
    output logic              has_int,
    output logic [DATA_W-1:0] ex_entry,
    output logic [DATA_W-1:0] era_pc
);

    logic              wr_en;
    csr_req_t          req;
    logic [DATA_W-1:0] trap_rdata;
    logic [DATA_W-1:0] timer_rdata;
    logic              timer_pending;

    csr_bus_port u_bus_port (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .sel         (sel),
        .ack         (ack),
        .dat_r       (dat_r),
        .wr_en       (wr_en),
        .req         (req),
        .trap_rdata  (trap_rdata),
        .timer_rdata (timer_rdata)
    );

    csr_trap_regs u_trap_regs (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .req           (req),
        .trap          (trap),
        .timer_pending (timer_pending),
        .rdata         (trap_rdata),
        .has_int       (has_int),
        .ex_entry      (ex_entry),
        .era_pc        (era_pc)
    );

    csr_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .req           (req),
        .rdata         (timer_rdata),
        .timer_pending (timer_pending)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module csr_tb -f flist.f -Mdir obj_dir -o csr_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csr_tb_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* testbench/csr_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_asserts (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        cyc,
    input wire logic        stb,
    input wire logic        ack,
    input wire logic        has_int,
    input wire logic [1:0]  estat_swi,
    input wire logic        timer_pending,
    input wire logic [12:0] ecfg_lie,
    input wire logic        crmd_ie
);

    int fail_count = 0;

    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cyc && stb) |=> ack)
    else begin
        fail_count = fail_count + 1;
        $error("ack missing one cycle after a new request");
    end

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else begin
        fail_count = fail_count + 1;
        $error("ack held longer than one cycle");
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(cyc && stb))
    else begin
        fail_count = fail_count + 1;
        $error("ack raised without a request");
    end

    ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
    else begin
        fail_count = fail_count + 1;
        $error("ack high right after reset");
    end

    // Software lines at bits 1 and 0, timer line at bit 11
    has_int_rule: assert property (@(posedge clk) disable iff (reset)
        has_int == (((estat_swi & ecfg_lie[1:0]) != 2'b0 || (timer_pending && ecfg_lie[11]))
                    && crmd_ie))
    else begin
        fail_count = fail_count + 1;
        $error("has_int does not follow ESTAT, ECFG and CRMD");
    end

endmodule

bind csr_unit csr_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .cyc           (cyc),
    .stb           (stb),
    .ack           (ack),
    .has_int       (has_int),
    .estat_swi     (u_trap_regs.estat_swi),
    .timer_pending (timer_pending),
    .ecfg_lie      (u_trap_regs.ecfg_lie),
    .crmd_ie       (u_trap_regs.crmd_ie)
);

`default_nettype wire

/* testbench/csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_tb import csr_pkg::*; ();

    localparam int TIMER_N = 6;
    // About 115 bus accesses of 3 cycles and three timer waits
    localparam int TEST_CYCLES = 8 + 3 * 115 + 3 * (4 * TIMER_N + 8);
    localparam int TIMEOUT = 2 * TEST_CYCLES;

    logic        clk = 1'b0;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    csr_num_e    adr;
    logic [31:0] dat_w;
    logic [31:0] sel;
    logic        ack;
    logic [31:0] dat_r;
    trap_event_t trap;
    logic        has_int;
    logic [31:0] ex_entry;
    logic [31:0] era_pc;

    logic [31:0] lfsr = 32'he155;
    logic [31:0] model [16384];
    logic [5:0]  exp_ecode;
    logic [8:0]  exp_esub;
    int          cycle_count;

    always #4 clk = ~clk;

    csr_unit dut (
        .clk      (clk),
        .reset    (reset),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .sel      (sel),
        .ack      (ack),
        .dat_r    (dat_r),
        .trap     (trap),
        .has_int  (has_int),
        .ex_entry (ex_entry),
        .era_pc   (era_pc)
    );

    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count > TIMEOUT) begin
            $display("timeout after %0d cycles", cycle_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (dut.u_asserts.fail_count != 0) begin
            $display("a concurrent assertion in csr_asserts failed");
            $display("Some tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Bits that exist in each register
    function automatic logic [31:0] writable_bits(csr_num_e n);
        case (n)
            CSR_CRMD, CSR_PRMD: return 32'h0000_0007;
            CSR_ECFG:   return 32'h0000_1bff;
            CSR_ESTAT:  return 32'h0000_0003;
            CSR_EENTRY: return 32'hffff_ffc0;
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] estat_value(logic pend);
        logic [31:0] v;
        v = {1'b0, exp_esub, exp_ecode, 16'b0};
        v[1:0] = model[CSR_ESTAT][1:0];
        v[11] = pend;
        return v;
    endfunction

    task automatic expect_equal(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic require(logic cond, string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic bus_access(logic write, csr_num_e n, logic [31:0] data,
                              logic [31:0] mask, output logic [31:0] rdata);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= write;
        adr <= n;
        dat_w <= data;
        sel <= mask;
        do begin
            @(negedge clk);
        end while (!ack);
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic write_csr(csr_num_e n, logic [31:0] data, logic [31:0] mask);
        logic [31:0] unused;
        bus_access(1'b1, n, data, mask, unused);
        model[n] = ((data & mask) | (model[n] & ~mask)) & writable_bits(n);
    endtask

    task automatic read_csr(csr_num_e n);
        logic [31:0] r;
        bus_access(1'b0, n, '0, '0, r);
        expect_equal(n.name(), r, model[n]);
    endtask

    task automatic raise_trap(trap_event_t ev);
        @(posedge clk);
        trap <= ev;
        @(posedge clk);
        trap <= '0;
    endtask

    task automatic enter_exception(ecode_e code, logic [8:0] sub, logic [31:0] pc,
                                   logic [31:0] vaddr);
        trap_event_t ev;
        logic [31:0] r;
        ev = '0;
        ev.ex = 1'b1;
        ev.ecode = code;
        ev.esubcode = sub;
        ev.pc = pc;
        ev.vaddr = vaddr;
        raise_trap(ev);
        model[CSR_PRMD] = model[CSR_CRMD] & 32'h7;
        model[CSR_CRMD] = '0;
        model[CSR_ERA] = pc;
        exp_ecode = code;
        exp_esub = sub;
        if (code == ECODE_ADE && sub == ESUBCODE_ADEF) begin
            model[CSR_BADV] = pc;
        end else if (code == ECODE_ADE || code == ECODE_ALE) begin
            model[CSR_BADV] = vaddr;
        end
        read_csr(CSR_CRMD);
        read_csr(CSR_PRMD);
        read_csr(CSR_BADV);
        read_csr(CSR_ERA);
        bus_access(1'b0, CSR_ESTAT, '0, '0, r);
        expect_equal("ESTAT", r, estat_value(1'b0));
        @(negedge clk);
        expect_equal("era_pc", era_pc, pc);
        expect_equal("ex_entry", ex_entry, model[CSR_EENTRY]);
    endtask

    task automatic wait_has_int(logic level, int deadline);
        do begin
            @(negedge clk);
        end while (has_int !== level && cycle_count <= deadline);
        expect_equal("has_int", 32'(has_int), 32'(level));
    endtask

    initial begin
        csr_num_e    regs [8] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                  CSR_ERA, CSR_EENTRY, CSR_ECFG, CSR_PRMD};
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] tval;
        logic [31:0] tval_next;
        logic [31:0] r;
        trap_event_t ev;
        int          start;

        reset <= 1'b1;
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        adr <= CSR_CRMD;
        dat_w <= '0;
        sel <= '0;
        trap <= '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        exp_ecode = '0;
        exp_esub = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_equal("ack", 32'(ack), 32'h0);
        expect_equal("has_int", 32'(has_int), 32'h0);

        for (int round = 0; round < 4; round++) begin
            foreach (regs[k]) begin
                data = next_rand();
                mask = next_rand();
                write_csr(regs[k], data, mask);
                read_csr(regs[k]);
            end
        end

        write_csr(CSR_CRMD, 32'h7, 32'hffff_ffff);
        enter_exception(ECODE_ADE, ESUBCODE_ADEF, 32'h1c00_0104, 32'h0bad_0001);
        write_csr(CSR_CRMD, 32'h5, 32'hffff_ffff);
        enter_exception(ECODE_ALE, 9'h000, 32'h1c00_0200, 32'h8000_0003);
        // Data address error reports the access address
        write_csr(CSR_CRMD, 32'h3, 32'hffff_ffff);
        enter_exception(ECODE_ADE, 9'h001, 32'h1c00_0280, 32'h0000_4002);
        write_csr(CSR_CRMD, 32'h6, 32'hffff_ffff);
        enter_exception(ECODE_SYS, 9'h000, 32'h1c00_0300, 32'h1234_5678);

        // Return picks up the saved mode
        write_csr(CSR_PRMD, 32'h5, 32'hffff_ffff);
        ev = '0;
        ev.ertn = 1'b1;
        raise_trap(ev);
        model[CSR_CRMD] = model[CSR_PRMD] & 32'h7;
        read_csr(CSR_CRMD);

        write_csr(CSR_ECFG, 32'h0000_0800, 32'hffff_ffff);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_TCFG, 32'(4 * TIMER_N + 1), 32'hffff_ffff);
        start = cycle_count;
        read_csr(CSR_TCFG);
        bus_access(1'b0, CSR_TVAL, '0, '0, tval);
        require(tval <= 32'(4 * TIMER_N), "TVAL above the loaded count");
        bus_access(1'b0, CSR_TVAL, '0, '0, tval_next);
        require(tval_next < tval, "TVAL did not count down");
        wait_has_int(1'b1, start + 4 * TIMER_N + 4);
        bus_access(1'b0, CSR_ESTAT, '0, '0, r);
        expect_equal("ESTAT", r, estat_value(1'b1));
        write_csr(CSR_TICLR, 32'h1, 32'hffff_ffff);
        @(negedge clk);
        expect_equal("has_int", 32'(has_int), 32'h0);
        bus_access(1'b0, CSR_ESTAT, '0, '0, r);
        expect_equal("ESTAT", r, estat_value(1'b0));

        write_csr(CSR_TCFG, 32'(4 * TIMER_N + 3), 32'hffff_ffff);
        start = cycle_count;
        wait_has_int(1'b1, start + 4 * TIMER_N + 4);
        write_csr(CSR_TICLR, 32'h1, 32'hffff_ffff);
        @(negedge clk);
        expect_equal("has_int", 32'(has_int), 32'h0);
        start = cycle_count;
        wait_has_int(1'b1, start + 4 * TIMER_N + 8);
        write_csr(CSR_TCFG, 32'h0, 32'hffff_ffff);
        write_csr(CSR_TICLR, 32'h1, 32'hffff_ffff);
        @(negedge clk);
        expect_equal("has_int", 32'(has_int), 32'h0);

        // Software interrupt lines one at a time, then both, then none
        write_csr(CSR_ECFG, 32'h3, 32'hffff_ffff);
        for (int v = 1; v <= 4; v++) begin
            write_csr(CSR_ESTAT, 32'(v % 4), 32'h3);
            @(negedge clk);
            expect_equal("has_int", 32'(has_int), 32'(v != 4));
        end
        bus_access(1'b0, CSR_ESTAT, '0, '0, r);
        expect_equal("ESTAT", r, estat_value(1'b0));

        @(negedge clk);
        if (dut.u_asserts.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
